/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := conv_post_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := Everything OK

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard rtl/*.svh bench/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/conv_post_ref.svh */
`ifndef CONV_POST_REF_SVH
`define CONV_POST_REF_SVH

////////////////////////////////////////
// stimulus source
////////////////////////////////////////

// 16 bit galois lfsr, taps x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
        nxt = nxt ^ 16'hB400;
    end
    return nxt;
endfunction

// low n bits of v read as two's complement
function automatic int sext(input logic [31:0] v, input int n);
    return $signed(v << (32 - n)) >>> (32 - n);
endfunction

////////////////////////////////////////
// expected pixels
////////////////////////////////////////

// (psum + bias) * tail, floor divided by 2^rank, then relu and clip to 8 bits
function automatic pixel_t requant_ref(input psum_t value, input quant_param_t qp);
    longint top;
    longint sum;
    longint prod;
    longint scaled;
    top    = (longint'(1) << `CONV_PIX_W) - 1;
    sum    = longint'(value) + longint'($signed(qp.bias));
    prod   = sum * longint'(qp.tail);      // tail never negative
    scaled = prod >>> qp.rank;
    if (scaled < 0) begin
        return '0;
    end
    if (scaled > top) begin
        return pixel_t'(top);
    end
    return pixel_t'(scaled);
endfunction

`endif

/* bench/conv_post_tb.sv */
`timescale 1ns/1ns
`include "conv_config.svh"

module conv_post_tb;

    import conv_num_pkg::*;
    import conv_stream_pkg::*;

    `include "conv_post_ref.svh"

    localparam int NUM_CASES   = 7;
    localparam int DRAIN_LIMIT = 50;

    typedef struct {
        string name;
        int    of;
        int    ox;
        int    oy;
        int    pset;    // 0 hand values, 1 fixed per channel, 2 lfsr
        int    beats;   // beats the tile has to take
        bit    gaps;
        bit    stray;   // beats before en, second en inside the tile
    } tile_case_t;

    typedef struct {
        pixel_beat_t px;
        int          due;   // cycle the beat must show up in
        int          idx;
    } expect_t;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         en;
    tile_shape_t  shape;
    logic         psum_valid;
    psum_beat_t   psum;
    logic         param_we;
    chan_idx_t    param_addr;
    quant_param_t param_data;
    logic         busy;
    logic         pix_valid;
    pixel_beat_t  pix;
    logic         tile_done;

    tile_case_t   cases [NUM_CASES];
    quant_param_t fixed_param [7];      // 4 hand sets, then 3 for channel tagging
    psum_t        hand_psum [16];
    pixel_t       hand_pix [16];
    quant_param_t chan_param [`CONV_CHANNELS];
    expect_t      exp_q [$];
    expect_t      cur;
    logic [15:0]  lfsr_state;
    int           cycle = 0;
    int           err_count = 0;
    int           case_errs [NUM_CASES] = '{default: 0};
    int           case_seen [NUM_CASES] = '{default: 0};
    int           tests_passed = 0;
    int           tests_failed = 0;
    int           waited;
    int           errs_before;

    conv_post_top u_dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////

    task automatic note_error(input int idx);
        err_count++;
        if (idx >= 0) begin
            case_errs[idx]++;
        end
    endtask

    task automatic check_value(input string sig, input int got, input int want, input int idx);
        assert (got == want) else begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, sig, got, want);
            note_error(idx);
        end
    endtask

    task automatic close_test(input string name, input int errs);
        if (errs == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("test %-8s %s, %0d errors", name, (errs == 0) ? "passed" : "FAILED", errs);
    endtask

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);     // one step per bit
            v[i] = lfsr_state[0];
        end
        return v;
    endfunction

    function automatic psum_beat_t random_beat(input int width);
        psum_beat_t b;
        for (int l = 0; l < `CONV_LANES; l++) begin
            b[l] = psum_t'(sext(rand_bits(width), width));
        end
        return b;
    endfunction

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic load_params(input int pset, input int of);
        quant_param_t qp;
        for (int ch = 0; ch < of; ch++) begin
            if (pset < 2) begin
                qp = fixed_param[ch + 4 * pset];
            end else begin
                qp.bias = bias_t'(sext(rand_bits(8), 8));
                qp.tail = tail_t'(rand_bits(8));
                qp.rank = rank_t'(rand_bits(3) + 8);
            end
            chan_param[ch] = qp;
            param_we   = 1'b1;
            param_addr = chan_idx_t'(ch);
            param_data = qp;
            @(posedge clk);
            #1;
        end
        param_we = 1'b0;
    endtask

    task automatic run_case(input int idx);
        tile_case_t row;
        psum_beat_t beat;
        expect_t    e;
        int         chan;
        row = cases[idx];
        load_params(row.pset, row.of);
        if (row.stray) begin
            psum_valid = 1'b1;          // the sequencer is idle so these must vanish
            repeat (3) begin
                psum = random_beat(12);
                @(posedge clk);
                #1;
            end
            psum_valid = 1'b0;
        end
        shape = '{of: dim_t'(row.of), ox: dim_t'(row.ox), oy: dim_t'(row.oy)};
        en    = 1'b1;
        @(posedge clk);
        #1;
        en    = 1'b0;
        shape = '1;                     // shape only counts at en
        for (int b = 0; b < row.beats; b++) begin
            if (row.gaps && rand_bits(1)) begin
                repeat (rand_bits(2) + 1) begin
                    @(posedge clk);
                    #1;
                end
            end
            chan = b / (row.beats / row.of);    // channels outer, pixel groups inner
            beat = random_beat((row.pset == 1) ? 8 : 12);
            e.idx     = idx;
            e.due     = cycle + 3;
            e.px.last = (b == row.beats - 1);
            for (int l = 0; l < `CONV_LANES; l++) begin
                if (row.pset == 0) begin
                    beat[l] = hand_psum[b * 4 + l];
                end
                e.px.lane[l] = requant_ref(beat[l], chan_param[chan]);
                if (row.pset == 0) begin
                    check_value($sformatf("reference pixel %0d", b * 4 + l), e.px.lane[l],
                                hand_pix[b * 4 + l], idx);
                end
            end
            exp_q.push_back(e);
            check_value("busy", busy, 1, idx);
            psum_valid = 1'b1;
            psum       = beat;
            en         = row.stray && (b == 1);     // no restart inside a tile
            @(posedge clk);
            #1;
            psum_valid = 1'b0;
            en         = 1'b0;
        end
        check_value("busy", busy, 0, idx);          // one cycle after the last beat
    endtask

    ////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////

    task automatic compare_beat(input expect_t e);
        assert (cycle == e.due) else begin
            $display("ERROR at %0t: output beat came in cycle %0d, due in cycle %0d",
                     $time, cycle, e.due);
            note_error(e.idx);
        end
        for (int l = 0; l < `CONV_LANES; l++) begin
            check_value($sformatf("pix.lane[%0d]", l), pix.lane[l], e.px.lane[l], e.idx);
        end
        check_value("pix.last", pix.last, e.px.last, e.idx);
        check_value("tile_done", tile_done, e.px.last, e.idx);
        case_seen[e.idx]++;
        if (case_seen[e.idx] == cases[e.idx].beats) begin
            close_test(cases[e.idx].name, case_errs[e.idx]);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && pix_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("ERROR at %0t: output beat that no input beat accounts for", $time);
                note_error(-1);
            end
            if (exp_q.size() != 0) begin
                cur = exp_q.pop_front();
                compare_beat(cur);
            end
        end else if (rst_n) begin
            check_value("tile_done", tile_done, 0, -1);
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        rst_n      = 1'b0;
        en         = 1'b0;
        shape      = '0;
        psum_valid = 1'b0;
        psum       = '0;
        param_we   = 1'b0;
        param_addr = '0;
        param_data = '0;
        lfsr_state = 16'd24447;
        cases[0] = '{"arith", 4, 2, 2, 0, 4, 1'b0, 1'b0};
        cases[1] = '{"chantag", 3, 4, 4, 1, 12, 1'b0, 1'b0};
        cases[2] = '{"dropped", 2, 4, 2, 2, 4, 1'b0, 1'b1};
        cases[3] = '{"rand_a", 2, 8, 2, 2, 8, 1'b1, 1'b0};
        cases[4] = '{"rand_b", 5, 4, 3, 2, 15, 1'b1, 1'b0};
        cases[5] = '{"rand_c", 1, 6, 6, 2, 9, 1'b1, 1'b0};
        cases[6] = '{"rand_d", 16, 2, 2, 2, 16, 1'b1, 1'b0};
        // identity, positive bias, clip both ways, rank shift; then three tag sets
        fixed_param = '{'{16'sd0, 16'd1, 5'd0}, '{16'sd100, 16'd1, 5'd0},
                        '{16'sd0, 16'd3, 5'd0}, '{16'sd16, 16'd40000, 5'd16},
                        '{16'sd10, 16'd2, 5'd1}, '{-16'sd20, 16'd5, 5'd2},
                        '{16'sd0, 16'd300, 5'd8}};
        hand_psum = '{0, 17, 255, 300, 5, 100, -50, 200,
                      -1, -1000, 90, 1000000, 100, -3, 0, 300};
        hand_pix  = '{0, 17, 255, 255, 105, 200, 50, 255,
                      0, 0, 255, 255, 70, 7, 9, 192};
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        errs_before = err_count;
        check_value("busy", busy, 0, -1);
        check_value("pix_valid", pix_valid, 0, -1);
        check_value("tile_done", tile_done, 0, -1);
        close_test("reset", err_count - errs_before);
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end
        for (waited = 0; waited < DRAIN_LIMIT && exp_q.size() != 0; waited++) begin
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: %0d output beats never arrived within %0d cycles",
                     exp_q.size(), DRAIN_LIMIT);
            $display("Something failed");
            $finish;
        end else begin
            repeat (5) @(posedge clk);      // room for stray outputs
            $display("summary: %0d tests passed, %0d failed, %0d errors",
                     tests_passed, tests_failed, err_count);
            if (err_count == 0 && tests_failed == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule

/* rtl/conv_config.svh */
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

////////////////////////////////////////
// stream geometry
////////////////////////////////////////

// pixels carried per beat
`define CONV_LANES      4

// depth of the per-channel parameter table
`define CONV_CHANNELS   16

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

`define CONV_PSUM_W     24  // 16 bit sum plus 8 bits headroom
`define CONV_BIAS_W     16  // signed bias
`define CONV_TAIL_W     16  // unsigned scale tail
`define CONV_RANK_W     5   // right shift amount
`define CONV_PIX_W      8   // unsigned output pixel

// of, ox and oy fields
`define CONV_DIM_W      16

`endif

/* rtl/conv_num_pkg.sv */
`include "conv_config.svh"

package conv_num_pkg;

    ////////////////////////////////////////
    // arithmetic words
    ////////////////////////////////////////

    // partial sum as produced by the array
    typedef logic signed [`CONV_PSUM_W-1:0] psum_t;

    // per-channel bias, added before scaling
    typedef logic signed [`CONV_BIAS_W-1:0] bias_t;

    typedef logic [`CONV_TAIL_W-1:0] tail_t;    // scale multiplier
    typedef logic [`CONV_RANK_W-1:0] rank_t;    // scale shift

    // clipped result
    typedef logic [`CONV_PIX_W-1:0] pixel_t;

    ////////////////////////////////////////
    // indices and sizes
    ////////////////////////////////////////

    // selects one entry of the parameter table
    typedef logic [$clog2(`CONV_CHANNELS)-1:0] chan_idx_t;

    typedef logic [`CONV_DIM_W-1:0] dim_t;      // tile shape field

endpackage

/* rtl/conv_post_top.sv */
`timescale 1ns/1ns

module conv_post_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          en,
    input  conv_stream_pkg::tile_shape_t  shape,
    input  logic                          psum_valid,
    input  conv_stream_pkg::psum_beat_t   psum,
    input  logic                          param_we,
    input  conv_num_pkg::chan_idx_t       param_addr,
    input  conv_stream_pkg::quant_param_t param_data,
    output logic                          busy,
    output logic                          pix_valid,
    output conv_stream_pkg::pixel_beat_t  pix,
    output logic                          tile_done
);

    import conv_num_pkg::*;
    import conv_stream_pkg::*;

    chan_idx_t    rd_chan;      // channel of the beat being taken
    logic         tag_valid;
    tagged_beat_t tag;
    quant_param_t param;        // follows rd_chan by one cycle

    ////////////////////////////////////////
    // beat tagging
    ////////////////////////////////////////

    tile_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .shape      (shape),
        .psum_valid (psum_valid),
        .psum       (psum),
        .busy       (busy),
        .tag_valid  (tag_valid),
        .tag        (tag),
        .rd_chan    (rd_chan)
    );

    quant_param_store u_store (
        .clk        (clk),
        .param_we   (param_we),
        .param_addr (param_addr),
        .param_data (param_data),
        .rd_chan    (rd_chan),
        .param      (param)
    );

    ////////////////////////////////////////
    // arithmetic, two stages
    ////////////////////////////////////////

    requant_unit u_requant (
        .clk        (clk),
        .rst_n      (rst_n),
        .tag_valid  (tag_valid),
        .tag        (tag),
        .param      (param),
        .pix_valid  (pix_valid),
        .pix        (pix),
        .tile_done  (tile_done)
    );

endmodule

/* rtl/conv_stream_pkg.sv */
`include "conv_config.svh"

package conv_stream_pkg;

    import conv_num_pkg::*;

    ////////////////////////////////////////
    // configuration records
    ////////////////////////////////////////

    // output plane of one tile
    typedef struct packed {
        dim_t of;   // output channels
        dim_t ox;   // plane width
        dim_t oy;   // plane height
    } tile_shape_t;

    // requantization set for one channel
    typedef struct packed {
        bias_t bias;
        tail_t tail;
        rank_t rank;
    } quant_param_t;

    ////////////////////////////////////////
    // beats between blocks
    ////////////////////////////////////////

    // lane 0 sits in the low bits
    typedef psum_t [`CONV_LANES-1:0] psum_beat_t;

    // accepted beat, flagged when it closes the tile
    typedef struct packed {
        psum_beat_t beat;
        logic       last;
    } tagged_beat_t;

    typedef struct packed {
        pixel_t [`CONV_LANES-1:0] lane;
        logic                     last;
    } pixel_beat_t;

    // sequencer states
    typedef enum logic {
        IDLE,
        RUN
    } seq_state_t;

endpackage

/* rtl/quant_param_store.sv */
`timescale 1ns/1ns
`include "conv_config.svh"

module quant_param_store (
    input  logic                          clk,
    input  logic                          param_we,
    input  conv_num_pkg::chan_idx_t       param_addr,
    input  conv_stream_pkg::quant_param_t param_data,
    input  conv_num_pkg::chan_idx_t       rd_chan,
    output conv_stream_pkg::quant_param_t param
);

    import conv_stream_pkg::*;

    ////////////////////////////////////////
    // parameter table
    ////////////////////////////////////////

    // one bias/tail/rank set per output channel
    quant_param_t mem [`CONV_CHANNELS];

    // software side write port
    always_ff @(posedge clk) begin
        if (param_we) begin
            mem[param_addr] <= param_data;
        end
    end

    // registered read
    // a read that meets a write to the same entry sees the old set
    always_ff @(posedge clk) begin
        param <= mem[rd_chan];
    end

endmodule

/* rtl/requant_unit.sv */
`timescale 1ns/1ns
`include "conv_config.svh"

module requant_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          tag_valid,
    input  conv_stream_pkg::tagged_beat_t tag,
    input  conv_stream_pkg::quant_param_t param,
    output logic                          pix_valid,
    output conv_stream_pkg::pixel_beat_t  pix,
    output logic                          tile_done
);

    import conv_num_pkg::*;
    import conv_stream_pkg::*;

    localparam int SUM_W   = `CONV_PSUM_W + 1;              // psum plus bias carry
    localparam int PROD_W  = SUM_W + `CONV_TAIL_W;          // 41 bit signed product
    localparam int PIX_MAX = (1 << `CONV_PIX_W) - 1;

    // stage 1 registers
    logic                    s1_valid;
    logic                    s1_last;
    logic signed [SUM_W-1:0] s1_sum [`CONV_LANES];
    tail_t                   s1_tail;
    rank_t                   s1_rank;

    // combinational lane results
    logic signed [SUM_W-1:0]  biased [`CONV_LANES];
    pixel_t [`CONV_LANES-1:0] clipped;

    ////////////////////////////////////////
    // stage 1: bias
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `CONV_LANES; i++) begin
            // both sides sign extend to SUM_W
            biased[i] = $signed(tag.beat[i]) + $signed(param.bias);
        end
    end

    ////////////////////////////////////////
    // stage 2: scale, shift, clip
    ////////////////////////////////////////

    always_comb begin
        logic signed [PROD_W-1:0] prod;
        logic signed [PROD_W-1:0] shifted;
        for (int i = 0; i < `CONV_LANES; i++) begin
            prod    = $signed(s1_sum[i]) * $signed({1'b0, s1_tail}); // tail is unsigned
            shifted = prod >>> s1_rank;
            if (shifted[PROD_W-1]) begin
                clipped[i] = '0;                                // relu
            end else if (shifted > PIX_MAX) begin
                clipped[i] = '1;                                // saturate
            end else begin
                clipped[i] = shifted[`CONV_PIX_W-1:0];
            end
        end
    end

    // valid pipe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            pix_valid <= 1'b0;
            tile_done <= 1'b0;
        end else begin
            s1_valid  <= tag_valid;
            pix_valid <= s1_valid;
            tile_done <= s1_valid && s1_last;   // pulses with the last pixels
        end
    end

    // data pipe
    always_ff @(posedge clk) begin
        if (tag_valid) begin
            s1_sum  <= biased;
            s1_tail <= param.tail;
            s1_rank <= param.rank;
            s1_last <= tag.last;
        end
        if (s1_valid) begin
            pix.lane <= clipped;
            pix.last <= s1_last;
        end
    end

endmodule

/* rtl/tile_sequencer.sv */
`timescale 1ns/1ns
`include "conv_config.svh"

module tile_sequencer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          en,
    input  conv_stream_pkg::tile_shape_t  shape,
    input  logic                          psum_valid,
    input  conv_stream_pkg::psum_beat_t   psum,
    output logic                          busy,
    output logic                          tag_valid,
    output conv_stream_pkg::tagged_beat_t tag,
    output conv_num_pkg::chan_idx_t       rd_chan
);

    import conv_num_pkg::*;
    import conv_stream_pkg::*;

    localparam int GRP_W   = 2 * `CONV_DIM_W;       // holds ox*oy without loss
    localparam int LANE_SH = $clog2(`CONV_LANES);

    seq_state_t       state;
    tile_shape_t      shape_q;      // shape of the running tile
    logic [GRP_W-1:0] grp_total;    // beats per channel
    logic [GRP_W-1:0] grp_cnt;      // pixel group inside the channel
    dim_t             chan_cnt;     // channel of the next beat
    logic             take;
    logic             grp_end;
    logic             chan_end;

    ////////////////////////////////////////
    // tile bookkeeping
    ////////////////////////////////////////

    // pixel groups per channel, rounded up to whole beats
    assign grp_total = (GRP_W'(shape_q.ox) * GRP_W'(shape_q.oy)
                        + GRP_W'(`CONV_LANES - 1)) >> LANE_SH;

    assign take     = (state == RUN) && psum_valid;
    assign grp_end  = (grp_cnt == grp_total - 1'b1);
    assign chan_end = (chan_cnt == shape_q.of - 1'b1);
    assign busy     = (state == RUN);

    // the store samples this at the same edge that takes the beat,
    // so its registered read lines up with tag one cycle later
    assign rd_chan = chan_idx_t'(chan_cnt);

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            grp_cnt   <= '0;
            chan_cnt  <= '0;
            tag_valid <= 1'b0;
        end else begin
            tag_valid <= take;
            case (state)
                IDLE: begin
                    if (en) begin           // start a fresh tile
                        state    <= RUN;
                        grp_cnt  <= '0;
                        chan_cnt <= '0;
                    end
                end
                RUN: begin
                    // en is ignored here
                    if (psum_valid) begin
                        if (grp_end) begin
                            grp_cnt  <= '0;
                            chan_cnt <= chan_cnt + 1'b1;
                            if (chan_end) begin
                                state <= IDLE;  // tile complete
                            end
                        end else begin
                            grp_cnt <= grp_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // shape and beat payload
    always_ff @(posedge clk) begin
        if (state == IDLE && en) begin
            shape_q <= shape;
        end
        if (take) begin
            tag.beat <= psum;
            tag.last <= grp_end && chan_end;
        end
    end

endmodule

/* sources.f */
+incdir+rtl
+incdir+bench
rtl/conv_num_pkg.sv
rtl/conv_stream_pkg.sv
rtl/tile_sequencer.sv
rtl/quant_param_store.sv
rtl/requant_unit.sv
rtl/conv_post_top.sv
bench/conv_post_tb.sv
